// File: logic/i2c_scl_timer.sv
// ***************************************************************************
// i2c_scl_timer
// down-counter timing the master SCL low and high phases
// ***************************************************************************
`timescale 1ns/10ps

module i2c_scl_timer import i2c_tx_pkg::*; (
    input  logic i2c_clk,
    input  logic i2c_rst_n,
    input  logic load_low,
    input  logic load_high,
    output logic phase_done
);

    logic [SCL_CNT_W-1:0] scl_cnt;

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            scl_cnt <= '0;
        end else if (load_low) begin
            scl_cnt <= SCL_CNT_W'(SCL_LOW_CYC);
        end else if (load_high) begin
            scl_cnt <= SCL_CNT_W'(SCL_HIGH_CYC);
        end else if (scl_cnt != '0) begin
            scl_cnt <= scl_cnt - 1'b1;
        end
    end

    // stays high while the counter sits at zero, so an idle timer reads as done
    assign phase_done = (scl_cnt == '0);

endmodule

// File: logic/i2c_tx_byte_select.sv
// ***************************************************************************
// i2c_tx_byte_select
// holds the loaded TX FIFO word and picks the byte that goes out on SDA
// ***************************************************************************
`timescale 1ns/10ps

module i2c_tx_byte_select import i2c_tx_pkg::*; (
    input  logic       i2c_clk,
    input  logic       i2c_rst_n,
    input  logic       load_tx_shifter,
    input  fifo_word_t tx_fifo_data_in,
    input  tar_t       ic_tar,
    input  tx_src_t    tx_src,
    input  logic       sent_10bit_addr2,
    input  logic       slv_tx_en,
    output byte_t      tx_byte
);

    fifo_word_t fifo_word;
    logic       cmd_bit;

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            fifo_word <= '0;
        end else if (load_tx_shifter) begin
            fifo_word <= tx_fifo_data_in;
        end
    end

    // command bit sits just above the data byte
    assign cmd_bit = fifo_word[BYTE_W];

    always_comb begin
        if (slv_tx_en) begin
            // a slave only ever returns read data
            tx_byte = fifo_word[BYTE_W-1:0];
        end else begin
            case (tx_src)
                SRC_GCALL:    tx_byte = GCALL_ADDR;
                SRC_START:    tx_byte = START_BYTE;
                SRC_ADDR10_1: tx_byte = {TENBIT_PREFIX, ic_tar[TAR_W-1 -: 2],
                                         cmd_bit & sent_10bit_addr2};
                SRC_ADDR10_2: tx_byte = ic_tar[BYTE_W-1:0];
                SRC_ADDR7:    tx_byte = {ic_tar[BYTE_W-2:0], cmd_bit};
                default:      tx_byte = fifo_word[BYTE_W-1:0];
            endcase
        end
    end

endmodule

// File: logic/i2c_tx_pkg.sv
// ***************************************************************************
// shared definitions for the I2C transmit shifter
// widths, fixed bus bytes, master SCL phase lengths, state and source enums
// ***************************************************************************
package i2c_tx_pkg;

    localparam int BYTE_W    = 8;
    // data byte in bits 7..0, command bit 8, two spare bits on top
    localparam int FIFO_W    = 11;
    localparam int TAR_W     = 10;
    localparam int BIT_CNT_W = 4;

    // counter value during the acknowledge clock
    localparam int ACK_BIT_CNT = 0;

    localparam logic [7:0] GCALL_ADDR    = 8'b0000_0000;
    localparam logic [7:0] START_BYTE    = 8'b0000_0001;
    localparam logic [4:0] TENBIT_PREFIX = 5'b11110;

    // each phase lasts one clock longer than the loaded count
    localparam int SCL_CNT_W    = 8;
    localparam int SCL_LOW_CYC  = 6;
    localparam int SCL_HIGH_CYC = 5;

    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [FIFO_W-1:0]    fifo_word_t;
    typedef logic [TAR_W-1:0]     tar_t;
    typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_CLK_LOAD,
        TX_CLK_LOW,
        TX_CLK_HIGH,
        TX_SLV_SHIFT,
        TX_DONE
    } tx_state_t;

    typedef enum logic [2:0] {
        SRC_DATA,
        SRC_GCALL,
        SRC_START,
        SRC_ADDR10_1,
        SRC_ADDR10_2,
        SRC_ADDR7
    } tx_src_t;

endpackage

// File: logic/i2c_tx_shift_fsm.sv
// ***************************************************************************
// i2c_tx_shift_fsm
// shift FSM and bit counter for master and slave transmit
// registered SCL, SDA and ack outputs, done pulses, data phase flags
// ***************************************************************************
`timescale 1ns/10ps

module i2c_tx_shift_fsm import i2c_tx_pkg::*; (
    input  logic  i2c_clk,
    input  logic  i2c_rst_n,
    input  logic  mst_tx_en,
    input  logic  slv_tx_en,
    input  logic  scl_edge_hl,
    input  logic  mst_b2b_txshift,
    input  logic  slv_b2b_txshift,
    input  logic  phase_done,
    input  byte_t tx_byte,
    output logic  load_low,
    output logic  load_high,
    output logic  mst_tx_scl_out,
    output logic  mst_tx_sda_out,
    output logic  slv_tx_sda_out,
    output logic  mst_tx_chk_ack,
    output logic  slv_tx_chk_ack,
    output logic  mst_tx_shift_done,
    output logic  slv_tx_shift_done,
    output logic  mst_txdata_phase,
    output logic  slv_txdata_phase
);

    tx_state_t state;
    tx_state_t nx_state;
    bit_cnt_t  bit_cnt;
    bit_cnt_t  bit_cnt_nxt;
    logic      load_cnt;
    logic      decr_cnt;
    logic      cnt_zero;
    logic      ack_clk;
    logic      shift_bit;
    logic [2:0] bit_idx;
    logic      mst_done_lvl;
    logic      mst_done_dly;
    logic      slv_done_lvl;
    logic      slv_done_dly;

    assign cnt_zero = (bit_cnt == bit_cnt_t'(ACK_BIT_CNT));

    assign mst_txdata_phase = mst_tx_en & ~cnt_zero;
    assign slv_txdata_phase = slv_tx_en & ~cnt_zero;

    // reload in idle and whenever a back-to-back byte starts from TX_DONE
    assign load_cnt = (state == TX_IDLE) |
                      ((state == TX_DONE) & (nx_state != TX_DONE) & (nx_state != TX_IDLE));
    assign decr_cnt = ~cnt_zero &
                      (((state == TX_CLK_HIGH) & (nx_state == TX_CLK_LOAD)) |
                       (slv_tx_en & scl_edge_hl));

    always_comb begin
        if (load_cnt) begin
            bit_cnt_nxt = bit_cnt_t'(BYTE_W);
        end else if (decr_cnt) begin
            bit_cnt_nxt = bit_cnt - 1'b1;
        end else begin
            bit_cnt_nxt = bit_cnt;
        end
    end

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            bit_cnt <= bit_cnt_t'(BYTE_W);
        end else begin
            bit_cnt <= bit_cnt_nxt;
        end
    end

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            state <= TX_IDLE;
        end else begin
            state <= nx_state;
        end
    end

    always_comb begin
        nx_state = state;
        case (state)
            TX_IDLE: begin
                if (mst_tx_en) begin
                    nx_state = TX_CLK_LOAD;
                end else if (slv_tx_en) begin
                    nx_state = TX_SLV_SHIFT;
                end
            end
            TX_CLK_LOAD, TX_CLK_LOW: begin
                if (!mst_tx_en) begin
                    nx_state = TX_IDLE;
                end else if (phase_done) begin
                    nx_state = TX_CLK_HIGH;
                end else begin
                    nx_state = TX_CLK_LOW;
                end
            end
            TX_CLK_HIGH: begin
                if (!mst_tx_en) begin
                    nx_state = TX_IDLE;
                end else if (phase_done) begin
                    nx_state = cnt_zero ? TX_DONE : TX_CLK_LOAD;
                end
            end
            TX_SLV_SHIFT: begin
                if (!slv_tx_en) begin
                    nx_state = TX_IDLE;
                end else if (cnt_zero && scl_edge_hl) begin
                    nx_state = TX_DONE;
                end
            end
            TX_DONE: begin
                if (!mst_tx_en && !slv_tx_en) begin
                    nx_state = TX_IDLE;
                end else if (mst_tx_en && mst_b2b_txshift) begin
                    nx_state = TX_CLK_LOAD;
                end else if (slv_tx_en && slv_b2b_txshift) begin
                    nx_state = TX_SLV_SHIFT;
                end
            end
            default: nx_state = TX_IDLE;
        endcase
    end

    // the timer is loaded one clock ahead so that it reads its count on phase entry
    assign load_low  = (nx_state == TX_CLK_LOAD);
    assign load_high = (nx_state == TX_CLK_HIGH) & (state != TX_CLK_HIGH);

    assign ack_clk   = (bit_cnt_nxt == bit_cnt_t'(ACK_BIT_CNT));
    assign bit_idx   = 3'(bit_cnt_nxt - 1'b1);
    assign shift_bit = ack_clk ? 1'b1 : tx_byte[bit_idx];

    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            mst_tx_scl_out <= 1'b1;
            mst_tx_sda_out <= 1'b1;
            slv_tx_sda_out <= 1'b1;
            mst_tx_chk_ack <= 1'b0;
            slv_tx_chk_ack <= 1'b0;
            mst_done_lvl   <= 1'b0;
            slv_done_lvl   <= 1'b0;
        end else begin
            mst_tx_scl_out <= 1'b1;
            mst_tx_sda_out <= 1'b1;
            slv_tx_sda_out <= 1'b1;
            mst_tx_chk_ack <= 1'b0;
            slv_tx_chk_ack <= 1'b0;
            mst_done_lvl   <= 1'b0;
            slv_done_lvl   <= 1'b0;
            case (nx_state)
                TX_CLK_LOAD, TX_CLK_LOW: begin
                    mst_tx_scl_out <= 1'b0;
                    mst_tx_sda_out <= shift_bit;
                    mst_tx_chk_ack <= ack_clk;
                end
                TX_CLK_HIGH: begin
                    mst_tx_sda_out <= shift_bit;
                    mst_tx_chk_ack <= ack_clk;
                end
                TX_SLV_SHIFT: begin
                    slv_tx_sda_out <= shift_bit;
                    slv_tx_chk_ack <= ack_clk;
                end
                TX_DONE: begin
                    // bus parked with SCL high until the next byte or an abort
                    mst_tx_chk_ack <= mst_tx_en;
                    slv_tx_chk_ack <= slv_tx_en;
                    mst_done_lvl   <= mst_tx_en;
                    slv_done_lvl   <= slv_tx_en;
                end
                default: ;
            endcase
        end
    end

    // rising edge of the done level gives a single pulse per byte
    always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
        if (!i2c_rst_n) begin
            mst_done_dly      <= 1'b0;
            slv_done_dly      <= 1'b0;
            mst_tx_shift_done <= 1'b0;
            slv_tx_shift_done <= 1'b0;
        end else begin
            mst_done_dly      <= mst_done_lvl;
            slv_done_dly      <= slv_done_lvl;
            mst_tx_shift_done <= mst_done_lvl & ~mst_done_dly;
            slv_tx_shift_done <= slv_done_lvl & ~slv_done_dly;
        end
    end

endmodule

// File: logic/i2c_txshifter_top.sv
// ***************************************************************************
// i2c_txshifter_top
// I2C transmit shifter built from byte select, SCL timer and shift FSM
// ***************************************************************************
`timescale 1ns/10ps

module i2c_txshifter_top import i2c_tx_pkg::*; (
    input  logic       i2c_clk,
    input  logic       i2c_rst_n,
    input  logic       mst_tx_en,
    input  logic       slv_tx_en,
    input  logic       scl_edge_hl,
    input  logic       mst_b2b_txshift,
    input  logic       slv_b2b_txshift,
    input  logic       load_tx_shifter,
    input  fifo_word_t tx_fifo_data_in,
    input  tx_src_t    tx_src,
    input  tar_t       ic_tar,
    input  logic       sent_10bit_addr2,
    output logic       mst_tx_scl_out,
    output logic       mst_tx_sda_out,
    output logic       slv_tx_sda_out,
    output logic       mst_tx_chk_ack,
    output logic       slv_tx_chk_ack,
    output logic       mst_tx_shift_done,
    output logic       slv_tx_shift_done,
    output logic       mst_txdata_phase,
    output logic       slv_txdata_phase
);

    byte_t tx_byte;
    logic  load_low;
    logic  load_high;
    logic  phase_done;

    i2c_tx_byte_select i_i2c_tx_byte_select (
        .i2c_clk          (i2c_clk),
        .i2c_rst_n        (i2c_rst_n),
        .load_tx_shifter  (load_tx_shifter),
        .tx_fifo_data_in  (tx_fifo_data_in),
        .ic_tar           (ic_tar),
        .tx_src           (tx_src),
        .sent_10bit_addr2 (sent_10bit_addr2),
        .slv_tx_en        (slv_tx_en),
        .tx_byte          (tx_byte)
    );

    // only used in master mode, a slave follows the external SCL strobe
    i2c_scl_timer i_i2c_scl_timer (
        .i2c_clk    (i2c_clk),
        .i2c_rst_n  (i2c_rst_n),
        .load_low   (load_low),
        .load_high  (load_high),
        .phase_done (phase_done)
    );

    i2c_tx_shift_fsm i_i2c_tx_shift_fsm (
        .i2c_clk           (i2c_clk),
        .i2c_rst_n         (i2c_rst_n),
        .mst_tx_en         (mst_tx_en),
        .slv_tx_en         (slv_tx_en),
        .scl_edge_hl       (scl_edge_hl),
        .mst_b2b_txshift   (mst_b2b_txshift),
        .slv_b2b_txshift   (slv_b2b_txshift),
        .phase_done        (phase_done),
        .tx_byte           (tx_byte),
        .load_low          (load_low),
        .load_high         (load_high),
        .mst_tx_scl_out    (mst_tx_scl_out),
        .mst_tx_sda_out    (mst_tx_sda_out),
        .slv_tx_sda_out    (slv_tx_sda_out),
        .mst_tx_chk_ack    (mst_tx_chk_ack),
        .slv_tx_chk_ack    (slv_tx_chk_ack),
        .mst_tx_shift_done (mst_tx_shift_done),
        .slv_tx_shift_done (slv_tx_shift_done),
        .mst_txdata_phase  (mst_txdata_phase),
        .slv_txdata_phase  (slv_txdata_phase)
    );

endmodule

// File: src.f
+incdir+tests
logic/i2c_tx_pkg.sv
logic/i2c_tx_byte_select.sv
logic/i2c_scl_timer.sv
logic/i2c_tx_shift_fsm.sv
logic/i2c_txshifter_top.sv
tests/i2c_txshifter_tb.sv

// File: tests/i2c_tx_model.svh
// ***************************************************************************
// reference model for the I2C transmit shifter testbench
// expected byte per source and the ten-step SDA sequence of one byte
// ***************************************************************************
`ifndef I2C_TX_MODEL_SVH
`define I2C_TX_MODEL_SVH

function automatic byte_t model_tx_byte(input logic       slave,
                                        input fifo_word_t word,
                                        input tar_t       tar,
                                        input tx_src_t    src,
                                        input logic       addr2);
    byte_t b;
    b = word[7:0];
    // a slave never sends anything but read data
    if (!slave) begin
        case (src)
            SRC_GCALL:    b = GCALL_ADDR;
            SRC_START:    b = START_BYTE;
            SRC_ADDR10_1: b = {TENBIT_PREFIX, tar[9], tar[8], word[8] & addr2};
            SRC_ADDR10_2: b = tar[7:0];
            SRC_ADDR7:    b = {tar[6:0], word[8]};
            default:      b = word[7:0];
        endcase
    end
    return b;
endfunction

// steps 0 to 7 carry the byte MSB first, step 8 is the ack clock, step 9 the parked bus
function automatic logic model_sda(input byte_t b, input int step);
    if (step < BYTE_W) begin
        return b[BYTE_W-1-step];
    end
    return 1'b1;
endfunction

`endif

// File: tests/i2c_txshifter_tb.sv
// ***************************************************************************
// testbench for the I2C transmit shifter
// random master, slave, back-to-back and aborted transfers against a model
// ***************************************************************************
`timescale 1ns/10ps

module i2c_txshifter_tb import i2c_tx_pkg::*; ();

    localparam int N_XFER      = 40;
    localparam int TIMEOUT_CYC = N_XFER * 9 * (SCL_LOW_CYC + SCL_HIGH_CYC + 6) + 2000;

    logic       i2c_clk;
    logic       i2c_rst_n;
    logic       mst_tx_en;
    logic       slv_tx_en;
    logic       scl_edge_hl;
    logic       mst_b2b_txshift;
    logic       slv_b2b_txshift;
    logic       load_tx_shifter;
    fifo_word_t tx_fifo_data_in;
    tx_src_t    tx_src;
    tar_t       ic_tar;
    logic       sent_10bit_addr2;
    logic       mst_tx_scl_out;
    logic       mst_tx_sda_out;
    logic       slv_tx_sda_out;
    logic       mst_tx_chk_ack;
    logic       slv_tx_chk_ack;
    logic       mst_tx_shift_done;
    logic       slv_tx_shift_done;
    logic       mst_txdata_phase;
    logic       slv_txdata_phase;
    integer     seed;
    int         cycle_cnt;

    `include "i2c_tx_model.svh"

    i2c_txshifter_top i_i2c_txshifter_top (.*);

    always #5 i2c_clk = ~i2c_clk;

    always @(posedge i2c_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYC));
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t: %s, expected %b got %b", $time, what, expected, actual));
        end
    endtask

    task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t: %s, expected %h got %h", $time, what, expected, actual));
        end
    endtask

    task automatic check_pulse(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t: %s, pulse expected %b got %b",
                               $time, what, expected, actual));
        end
    endtask

    // loads a random FIFO word with random source and target, returns the model byte
    task automatic load_word(input logic slave, output byte_t exp);
        fifo_word_t word;
        tar_t       tar;
        tx_src_t    src;
        logic       addr2;
        int         rnd;
        word  = fifo_word_t'($random(seed));
        tar   = tar_t'($random(seed));
        rnd   = $unsigned($random(seed)) % 6;
        src   = tx_src_t'(rnd[2:0]);
        rnd   = $random(seed);
        addr2 = rnd[0];
        exp   = model_tx_byte(slave, word, tar, src, addr2);
        @(posedge i2c_clk);
        load_tx_shifter  <= 1'b1;
        tx_fifo_data_in  <= word;
        ic_tar           <= tar;
        tx_src           <= src;
        sent_10bit_addr2 <= addr2;
        @(posedge i2c_clk);
        load_tx_shifter  <= 1'b0;
    endtask

    task automatic check_idle(input string when);
        @(negedge i2c_clk);
        check_bit(mst_tx_scl_out, 1'b1, {when, ": SCL"});
        check_bit(mst_tx_sda_out, 1'b1, {when, ": master SDA"});
        check_bit(slv_tx_sda_out, 1'b1, {when, ": slave SDA"});
        check_bit(mst_tx_chk_ack | slv_tx_chk_ack, 1'b0, {when, ": chk_ack"});
        check_pulse(mst_tx_shift_done | slv_tx_shift_done, 1'b0, {when, ": shift done"});
        check_bit(mst_txdata_phase | slv_txdata_phase, 1'b0, {when, ": data phase"});
    endtask

    task automatic wait_done(input logic master);
        int   waited;
        logic seen;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < 20) begin
            @(negedge i2c_clk);
            waited++;
            seen = master ? mst_tx_shift_done : slv_tx_shift_done;
        end
        check_pulse(seen, 1'b1, "no shift done pulse after the byte");
        @(negedge i2c_clk);
        check_pulse(master ? mst_tx_shift_done : slv_tx_shift_done, 1'b0,
                    "shift done longer than one cycle");
    endtask

    // samples SDA on every rising SCL edge, the bus starts parked high
    task automatic master_byte(input byte_t exp);
        byte_t got;
        logic  scl_prev;
        logic  sda_prev;
        int    edges;
        int    waited;
        got      = '0;
        scl_prev = 1'b1;
        sda_prev = 1'b1;
        edges    = 0;
        waited   = 0;
        while (edges < 9) begin
            @(negedge i2c_clk);
            waited++;
            if (waited > 400) begin
                fail_run("master byte stalled, SCL stopped toggling");
            end
            if (scl_prev && mst_tx_scl_out) begin
                check_bit(mst_tx_sda_out, sda_prev, "SDA changed while SCL high");
            end
            check_pulse(mst_tx_shift_done, 1'b0, "master done before the byte ended");
            if (!scl_prev && mst_tx_scl_out) begin
                check_bit(mst_tx_chk_ack, edges == 8, "master chk_ack");
                check_bit(mst_txdata_phase, edges < 8, "master data phase flag");
                if (edges < 8) begin
                    got = {got[6:0], mst_tx_sda_out};
                end else begin
                    check_bit(mst_tx_sda_out, model_sda(exp, 8), "master SDA in ack clock");
                end
                edges++;
            end
            scl_prev = mst_tx_scl_out;
            sda_prev = mst_tx_sda_out;
        end
        check_byte(got, exp, "master byte on SDA");
        wait_done(1'b1);
        check_bit(mst_tx_scl_out, 1'b1, "SCL parked after the byte");
        check_bit(mst_tx_sda_out, model_sda(exp, 9), "master SDA parked after the byte");
        check_bit(mst_tx_chk_ack, 1'b1, "master chk_ack while parked");
    endtask

    task automatic slave_byte(input byte_t exp);
        byte_t got;
        int    step;
        int    gap;
        got = '0;
        for (step = 0; step < 9; step++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge i2c_clk);
            @(negedge i2c_clk);
            check_bit(slv_tx_sda_out, model_sda(exp, step), "slave SDA before strobe");
            check_bit(slv_tx_chk_ack, step == 8, "slave chk_ack");
            check_bit(slv_txdata_phase, step < 8, "slave data phase flag");
            check_pulse(slv_tx_shift_done, 1'b0, "slave done before the byte ended");
            if (step < 8) begin
                got = {got[6:0], slv_tx_sda_out};
            end
            @(posedge i2c_clk);
            scl_edge_hl <= 1'b1;
            @(posedge i2c_clk);
            scl_edge_hl <= 1'b0;
        end
        check_byte(got, exp, "slave byte on SDA");
        wait_done(1'b0);
        check_bit(slv_tx_sda_out, model_sda(exp, 9), "slave SDA parked after the byte");
        check_bit(slv_tx_chk_ack, 1'b1, "slave chk_ack while parked");
    endtask

    task automatic drop_enable(input string when);
        @(posedge i2c_clk);
        mst_tx_en <= 1'b0;
        slv_tx_en <= 1'b0;
        @(posedge i2c_clk);
        check_idle(when);
    endtask

    // one byte, then extra bytes started back to back from the parked state
    task automatic run_transfer(input logic master, input int extra);
        byte_t exp;
        int    i;
        load_word(!master, exp);
        mst_tx_en <= master;
        slv_tx_en <= !master;
        @(posedge i2c_clk);
        for (i = 0; i <= extra; i++) begin
            if (i > 0) begin
                load_word(!master, exp);
                mst_b2b_txshift <= master;
                slv_b2b_txshift <= !master;
                @(posedge i2c_clk);
                mst_b2b_txshift <= 1'b0;
                slv_b2b_txshift <= 1'b0;
                // a restart straight from TX_DONE reloads the bit counter on the strobe edge
                @(negedge i2c_clk);
                check_bit(master ? mst_txdata_phase : slv_txdata_phase, 1'b1,
                          "back-to-back byte passed through idle");
            end
            if (master) begin
                master_byte(exp);
            end else begin
                slave_byte(exp);
            end
        end
        drop_enable("after transfer");
    endtask

    task automatic abort_transfer(input logic master);
        byte_t exp;
        int    hold;
        int    i;
        load_word(!master, exp);
        mst_tx_en <= master;
        slv_tx_en <= !master;
        hold = master ? 3 + $unsigned($random(seed)) % 45 : 1 + $unsigned($random(seed)) % 7;
        for (i = 0; i < hold; i++) begin
            @(posedge i2c_clk);
            scl_edge_hl <= !master;
            @(posedge i2c_clk);
            scl_edge_hl <= 1'b0;
        end
        drop_enable("after abort");
        for (i = 0; i < 30; i++) begin
            check_idle("after abort");
        end
    endtask

    initial begin
        int n;
        seed             = 23140;
        cycle_cnt        = 0;
        i2c_clk          = 1'b0;
        i2c_rst_n        = 1'b0;
        mst_tx_en        = 1'b0;
        slv_tx_en        = 1'b0;
        scl_edge_hl      = 1'b0;
        mst_b2b_txshift  = 1'b0;
        slv_b2b_txshift  = 1'b0;
        load_tx_shifter  = 1'b0;
        tx_fifo_data_in  = '0;
        tx_src           = SRC_DATA;
        ic_tar           = '0;
        sent_10bit_addr2 = 1'b0;
        repeat (5) @(posedge i2c_clk);
        i2c_rst_n <= 1'b1;
        check_idle("after reset");
        for (n = 0; n < 12; n++) begin
            run_transfer(1'b1, 0);
            run_transfer(1'b0, 0);
        end
        for (n = 0; n < 2; n++) begin
            run_transfer(1'b1, 2);
            run_transfer(1'b0, 2);
        end
        for (n = 0; n < 2; n++) begin
            abort_transfer(1'b1);
            abort_transfer(1'b0);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
